// File: common/frontend_pkg.sv
// shared widths, sizes, opcodes and fetch entry type of the instruction fetch front end
package frontend_pkg;

  // ----------------------------------------------------------------------
  // widths and sizes
  // ----------------------------------------------------------------------
  // address and instruction word width
  localparam int unsigned addr_w = 32;
  typedef logic [addr_w-1:0] addr_t;

  // branch history table, indexed by pc[7:2]
  localparam int unsigned bht_entries = 64;
  localparam int unsigned bht_idx_w   = $clog2(bht_entries);

  // return address stack
  localparam int unsigned ras_depth = 4;
  localparam int unsigned ras_ptr_w = $clog2(ras_depth);

  // fetch queue towards decode
  localparam int unsigned queue_depth = 4;

  // ----------------------------------------------------------------------
  // rv32i control-flow opcodes
  // ----------------------------------------------------------------------
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;

  // ----------------------------------------------------------------------
  // control-flow kind and queue payload
  // ----------------------------------------------------------------------
  typedef enum logic [2:0] {
    no_cf,
    branch,
    jump,
    jump_r,
    ret
  } cf_e;

  // one fetched instruction with its prediction
  typedef struct packed {
    addr_t instr;
    addr_t pc;
    cf_e   cf;
    // predicted next pc, pc+4 when nothing is predicted
    addr_t target;
  } fetch_entry_t;

endpackage

// File: common/fetch_if.sv
// fetch entry handoff between the fetch stage and the fetch queue
`timescale 1ns/1ps

interface fetch_if;

  // one scanned entry, valid for a single cycle
  logic                       valid;
  frontend_pkg::fetch_entry_t entry;
  // queue has room for everything still in flight
  logic                       ready;
  // entry taken by the queue this cycle
  logic                       push;

  // fetch stage side
  modport producer (
    output valid,
    output entry,
    input  ready,
    input  push
  );

  // queue side
  modport consumer (
    input  valid,
    input  entry,
    output ready,
    output push
  );

endinterface

// File: predict/instr_scan.sv
// rv32i control-flow decoder returning the kind of jump and its immediate
`timescale 1ns/1ps

module instr_scan (
  input  frontend_pkg::addr_t instr_i,
  output logic                is_branch_o,
  output logic                is_jal_o,
  output logic                is_jalr_o,
  output logic                is_call_o,
  output logic                is_return_o,
  output frontend_pkg::addr_t imm_o
);

  logic [6:0] opcode;
  logic [4:0] rd;
  logic [4:0] rs1;
  logic       rd_link;
  logic       rs1_link;

  assign opcode = instr_i[6:0];
  assign rd     = instr_i[11:7];
  assign rs1    = instr_i[19:15];

  // x1 and x5 are the link registers
  assign rd_link  = (rd == 5'd1) || (rd == 5'd5);
  assign rs1_link = (rs1 == 5'd1) || (rs1 == 5'd5);

  assign is_branch_o = (opcode == frontend_pkg::op_branch);
  assign is_jal_o    = (opcode == frontend_pkg::op_jal);
  // jalr only with funct3 000
  assign is_jalr_o   = (opcode == frontend_pkg::op_jalr) && (instr_i[14:12] == 3'b000);

  // call writes a link register
  assign is_call_o   = (is_jal_o | is_jalr_o) & rd_link;
  // return jumps through a link register and discards the link
  assign is_return_o = is_jalr_o & rs1_link & (rd == 5'd0);

  // j-type immediate for jal, b-type otherwise
  // jalr target needs rs1 so its immediate is never used here
  always_comb begin
    if (is_jal_o) begin
      imm_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
    end else begin
      imm_o = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    end
  end

endmodule

// File: predict/bht.sv
// branch history table of 2-bit saturating counters
`timescale 1ns/1ps

module bht (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  frontend_pkg::addr_t pc_i,
  input  logic                upd_valid_i,
  input  frontend_pkg::addr_t upd_pc_i,
  input  logic                upd_taken_i,
  output logic                taken_o
);

  logic [1:0] cnt_q [frontend_pkg::bht_entries];

  logic [frontend_pkg::bht_idx_w-1:0] rd_idx;
  logic [frontend_pkg::bht_idx_w-1:0] upd_idx;

  // word aligned pc, drop the low two bits
  assign rd_idx  = pc_i[frontend_pkg::bht_idx_w+1:2];
  assign upd_idx = upd_pc_i[frontend_pkg::bht_idx_w+1:2];

  // upper counter bit predicts taken
  assign taken_o = cnt_q[rd_idx][1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // weakly not taken
      for (int i = 0; i < frontend_pkg::bht_entries; i++) begin
        cnt_q[i] <= 2'b01;
      end
    end else if (upd_valid_i) begin
      // saturate at 11 and 00
      if (upd_taken_i && cnt_q[upd_idx] != 2'b11) begin
        cnt_q[upd_idx] <= cnt_q[upd_idx] + 2'b01;
      end else if (!upd_taken_i && cnt_q[upd_idx] != 2'b00) begin
        cnt_q[upd_idx] <= cnt_q[upd_idx] - 2'b01;
      end
    end
  end

endmodule

// File: predict/ras.sv
// circular return address stack, oldest entry overwritten when full
`timescale 1ns/1ps

module ras (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                push_i,
  input  logic                pop_i,
  input  frontend_pkg::addr_t data_i,
  output logic                valid_o,
  output frontend_pkg::addr_t ra_o
);

  frontend_pkg::addr_t mem_q [frontend_pkg::ras_depth];

  logic [frontend_pkg::ras_ptr_w-1:0] top_q;
  logic [frontend_pkg::ras_ptr_w-1:0] wr_ptr;
  logic [frontend_pkg::ras_ptr_w:0]   cnt_q;
  logic                               full;

  // pointer wraps around the stack
  assign wr_ptr  = top_q + 1'b1;
  assign full    = (cnt_q == frontend_pkg::ras_depth[frontend_pkg::ras_ptr_w:0]);
  assign valid_o = (cnt_q != '0);
  assign ra_o    = mem_q[top_q];

  // pointer and fill level
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      top_q <= '0;
      cnt_q <= '0;
    end else if (push_i) begin
      top_q <= wr_ptr;
      // full stack keeps its count, the oldest slot is reused
      if (!full) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end else if (pop_i && valid_o) begin
      top_q <= top_q - 1'b1;
      cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr] <= data_i;
    end
  end

endmodule

// File: src/pc_gen.sv
// next-pc register and fetch address selection for the instruction memory
`timescale 1ns/1ps

module pc_gen (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  frontend_pkg::addr_t boot_addr_i,
  input  logic                fetch_ready_i,
  input  logic                bp_valid_i,
  input  frontend_pkg::addr_t bp_target_i,
  input  logic                redirect_i,
  input  frontend_pkg::addr_t redirect_pc_i,
  input  logic                mispredict_i,
  input  frontend_pkg::addr_t mispredict_pc_i,
  output frontend_pkg::addr_t fetch_addr_o,
  output logic                fetch_req_o
);

  frontend_pkg::addr_t npc_d, npc_q;
  // first cycle out of reset loads the boot address
  logic                load_boot_q;

  // no request while the boot address is being loaded
  assign fetch_req_o = fetch_ready_i & ~load_boot_q;

  always_comb begin
    // fetch address: boot, npc, or predicted target
    if (load_boot_q) begin
      fetch_addr_o = boot_addr_i;
    end else begin
      fetch_addr_o = npc_q;
    end
    if (bp_valid_i) begin
      fetch_addr_o = bp_target_i;
    end
    // hold the fetch address when no request leaves
    npc_d = fetch_addr_o;
    // lowest precedence first, later ones override
    if (fetch_req_o) begin
      npc_d = fetch_addr_o + 32'd4;
    end
    if (mispredict_i) begin
      npc_d = mispredict_pc_i;
    end
    if (redirect_i) begin
      npc_d = redirect_pc_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      load_boot_q <= 1'b1;
      npc_q       <= '0;
    end else begin
      load_boot_q <= 1'b0;
      npc_q       <= npc_d;
    end
  end

endmodule

// File: src/fetch_stage.sv
// fetch response register, kill control and branch prediction
`timescale 1ns/1ps

module fetch_stage (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                rsp_valid_i,
  input  frontend_pkg::addr_t rsp_addr_i,
  input  frontend_pkg::addr_t rsp_data_i,
  input  logic                redirect_i,
  input  logic                mispredict_i,
  input  logic                resolve_valid_i,
  input  frontend_pkg::addr_t resolve_pc_i,
  input  logic                resolve_taken_i,
  input  logic                resolve_is_branch_i,
  output logic                kill_o,
  output logic                bp_valid_o,
  output frontend_pkg::addr_t bp_target_o,
  fetch_if.producer           fetch_bus
);

  logic                rsp_valid_q;
  // next response was requested from the stale pc
  logic                drop_q;
  frontend_pkg::addr_t rsp_pc_q, rsp_instr_q;

  logic                flush, entry_valid, taken;
  logic                is_branch, is_jal, is_jalr, is_call, is_return;
  frontend_pkg::addr_t imm, pc_plus4, pc_rel, target;
  logic                bht_taken, ras_valid;
  frontend_pkg::addr_t ras_ra;
  frontend_pkg::cf_e   cf;

  assign flush       = redirect_i | mispredict_i;
  // registered entry is stale once the back end redirects
  assign entry_valid = rsp_valid_q & ~flush;
  assign pc_plus4    = rsp_pc_q + 32'd4;
  assign pc_rel      = rsp_pc_q + imm;

  instr_scan i_instr_scan (
    .instr_i     (rsp_instr_q),
    .is_branch_o (is_branch),
    .is_jal_o    (is_jal),
    .is_jalr_o   (is_jalr),
    .is_call_o   (is_call),
    .is_return_o (is_return),
    .imm_o       (imm)
  );

  // ----------------------------------------------------------------------
  // prediction
  // ----------------------------------------------------------------------
  always_comb begin
    cf     = frontend_pkg::no_cf;
    target = pc_plus4;
    taken  = 1'b0;
    if (is_jal) begin
      cf     = frontend_pkg::jump;
      target = pc_rel;
      taken  = 1'b1;
    end else if (is_branch) begin
      cf = frontend_pkg::branch;
      if (bht_taken) begin
        target = pc_rel;
        taken  = 1'b1;
      end
    end else if (is_return) begin
      cf = frontend_pkg::ret;
      // empty stack falls through to pc+4
      if (ras_valid) begin
        target = ras_ra;
        taken  = 1'b1;
      end
    end else if (is_jalr) begin
      // no target buffer, so no prediction
      cf = frontend_pkg::jump_r;
    end
  end

  assign bp_valid_o  = entry_valid & taken;
  assign bp_target_o = target;
  // predicted redirect only drops the response now arriving
  assign kill_o      = bp_valid_o | flush;

  bht i_bht (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .pc_i        (rsp_pc_q),
    .upd_valid_i (resolve_valid_i & resolve_is_branch_i),
    .upd_pc_i    (resolve_pc_i),
    .upd_taken_i (resolve_taken_i),
    .taken_o     (bht_taken)
  );

  // stack moves only for entries the queue took
  ras i_ras (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (fetch_bus.push & is_call),
    .pop_i   (fetch_bus.push & is_return),
    .data_i  (pc_plus4),
    .valid_o (ras_valid),
    .ra_o    (ras_ra)
  );

  // ----------------------------------------------------------------------
  // queue handoff
  // ----------------------------------------------------------------------
  assign fetch_bus.valid = entry_valid;
  assign fetch_bus.entry = '{instr: rsp_instr_q, pc: rsp_pc_q, cf: cf, target: target};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
      drop_q      <= 1'b0;
    end else begin
      rsp_valid_q <= rsp_valid_i & ~kill_o & ~drop_q;
      drop_q      <= flush;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsp_valid_i) begin
      rsp_pc_q    <= rsp_addr_i;
      rsp_instr_q <= rsp_data_i;
    end
  end

endmodule

// File: src/fetch_queue.sv
// fetch queue between fetch and decode, with a generic payload
`timescale 1ns/1ps

module fetch_queue #(
  parameter type         entry_t = logic,
  parameter int unsigned depth   = frontend_pkg::queue_depth
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     flush_i,
  fetch_if.consumer in_bus,
  output logic     out_valid_o,
  output entry_t   out_entry_o,
  input  logic     out_ready_i
);

  localparam int unsigned ptr_w = $clog2(depth);
  localparam int unsigned cnt_w = $clog2(depth + 1);

  entry_t mem_q [depth];

  logic [ptr_w-1:0] wr_ptr_q, rd_ptr_q;
  logic [cnt_w-1:0] cnt_q;
  logic             pop;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    next_ptr = (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // room for the registered entry, the response in flight and a new request
  assign in_bus.ready = (cnt_q < cnt_w'(depth - 2));
  // requests stop early enough that every entry finds a slot
  assign in_bus.push  = in_bus.valid;

  assign out_valid_o = (cnt_q != '0);
  assign out_entry_o = mem_q[rd_ptr_q];
  assign pop         = out_valid_o & out_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      // drop everything in one cycle
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (in_bus.push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // simultaneous push and pop keeps the count
      if (in_bus.push && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (!in_bus.push && pop) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_bus.push) begin
      mem_q[wr_ptr_q] <= in_bus.entry;
    end
  end

endmodule

// File: src/frontend.sv
// rv32i instruction fetch front end top level
`timescale 1ns/1ps

module frontend (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  frontend_pkg::addr_t boot_addr_i,
  // instruction memory
  output logic                fetch_req_o,
  output frontend_pkg::addr_t fetch_addr_o,
  output logic                kill_o,
  input  logic                rsp_valid_i,
  input  frontend_pkg::addr_t rsp_addr_i,
  input  frontend_pkg::addr_t rsp_data_i,
  // back end redirect and resolve
  input  logic                redirect_i,
  input  frontend_pkg::addr_t redirect_pc_i,
  input  logic                resolve_valid_i,
  input  frontend_pkg::addr_t resolve_pc_i,
  input  logic                resolve_taken_i,
  input  logic                resolve_mispredict_i,
  input  logic                resolve_is_branch_i,
  input  frontend_pkg::addr_t resolve_target_i,
  // decode
  output logic                fetch_valid_o,
  output frontend_pkg::addr_t fetch_instr_o,
  output frontend_pkg::addr_t fetch_pc_o,
  output frontend_pkg::cf_e   fetch_cf_o,
  output frontend_pkg::addr_t fetch_target_o,
  input  logic                fetch_ready_i
);

  logic                       mispredict, bp_valid;
  frontend_pkg::addr_t        bp_target;
  frontend_pkg::fetch_entry_t head;

  fetch_if fetch_bus ();

  assign mispredict = resolve_valid_i & resolve_mispredict_i;

  pc_gen i_pc_gen (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .boot_addr_i     (boot_addr_i),
    .fetch_ready_i   (fetch_bus.ready),
    .bp_valid_i      (bp_valid),
    .bp_target_i     (bp_target),
    .redirect_i      (redirect_i),
    .redirect_pc_i   (redirect_pc_i),
    .mispredict_i    (mispredict),
    .mispredict_pc_i (resolve_target_i),
    .fetch_addr_o    (fetch_addr_o),
    .fetch_req_o     (fetch_req_o)
  );

  fetch_stage i_fetch_stage (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .rsp_valid_i         (rsp_valid_i),
    .rsp_addr_i          (rsp_addr_i),
    .rsp_data_i          (rsp_data_i),
    .redirect_i          (redirect_i),
    .mispredict_i        (mispredict),
    .resolve_valid_i     (resolve_valid_i),
    .resolve_pc_i        (resolve_pc_i),
    .resolve_taken_i     (resolve_taken_i),
    .resolve_is_branch_i (resolve_is_branch_i),
    .kill_o              (kill_o),
    .bp_valid_o          (bp_valid),
    .bp_target_o         (bp_target),
    .fetch_bus           (fetch_bus.producer)
  );

  // queue empties on any back end redirect
  fetch_queue #(
    .entry_t (frontend_pkg::fetch_entry_t),
    .depth   (frontend_pkg::queue_depth)
  ) i_fetch_queue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (redirect_i | mispredict),
    .in_bus      (fetch_bus.consumer),
    .out_valid_o (fetch_valid_o),
    .out_entry_o (head),
    .out_ready_i (fetch_ready_i)
  );

  // head entry split onto the decode ports
  assign fetch_instr_o  = head.instr;
  assign fetch_pc_o     = head.pc;
  assign fetch_cf_o     = head.cf;
  assign fetch_target_o = head.target;

endmodule

// File: test/frontend_assert.sv
// concurrent checks on the front end top level, bound into the design
`timescale 1ns/1ps

module frontend_assert (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                redirect_i,
  input logic                mispredict_i,
  input logic                kill_o,
  input logic                rsp_valid_i,
  input logic                push_i,
  input logic                fetch_req_o,
  input logic                fetch_valid_o,
  input logic                fetch_ready_i,
  input frontend_pkg::addr_t fetch_pc_o
);

  // queue fill level rebuilt from push, pop and flush
  logic [$clog2(frontend_pkg::queue_depth + 1)-1:0] fill_q;
  logic                                             pop;

  assign pop = fetch_valid_o & fetch_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fill_q <= '0;
    end else if (redirect_i || mispredict_i) begin
      fill_q <= '0;
    end else if (push_i && !pop) begin
      fill_q <= fill_q + 1'b1;
    end else if (!push_i && pop) begin
      fill_q <= fill_q - 1'b1;
    end
  end

  // a response arriving under kill never reaches the queue
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (kill_o && rsp_valid_i) |=> !push_i)
    else $error("killed response pushed into the queue");

  // head holds under back-pressure
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (fetch_valid_o && !fetch_ready_i && !redirect_i && !mispredict_i)
      |=> (fetch_valid_o && $stable(fetch_pc_o)))
    else $error("head entry changed while decode stalled");

  // requests stop two entries before full
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_req_o |-> (fill_q < frontend_pkg::queue_depth - 2))
    else $error("request issued with queue nearly full");

endmodule

bind frontend frontend_assert u_frontend_assert (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .redirect_i    (redirect_i),
  .mispredict_i  (resolve_valid_i & resolve_mispredict_i),
  .kill_o        (kill_o),
  .rsp_valid_i   (rsp_valid_i),
  .push_i        (fetch_bus.push),
  .fetch_req_o   (fetch_req_o),
  .fetch_valid_o (fetch_valid_o),
  .fetch_ready_i (fetch_ready_i),
  .fetch_pc_o    (fetch_pc_o)
);

// File: test/tb_frontend.sv
// testbench for the fetch front end with random memory image and cycle reference model
`timescale 1ns/1ps

module tb_frontend;

  localparam int unsigned n_tests = 2000;
  localparam int unsigned words   = 256;

  // ----------------------------------------------------------------------
  // DUT signals
  // ----------------------------------------------------------------------
  logic clk_i, rst_ni, redirect_i, fetch_ready_i, rsp_valid_i;
  logic resolve_valid_i, resolve_taken_i, resolve_mispredict_i, resolve_is_branch_i;
  logic fetch_req_o, kill_o, fetch_valid_o;
  frontend_pkg::addr_t boot_addr_i, redirect_pc_i, resolve_pc_i, resolve_target_i;
  frontend_pkg::addr_t rsp_addr_i, rsp_data_i, fetch_addr_o;
  frontend_pkg::addr_t fetch_instr_o, fetch_pc_o, fetch_target_o;
  frontend_pkg::cf_e   fetch_cf_o;

  // memory image, with kind and offset kept from generation
  // kind 0 alu, 1 branch, 2 jal, 3 call, 4 return
  logic [31:0] mem [words];
  logic [2:0]  kind_mem [words];
  logic [31:0] imm_mem [words];
  logic        pend_v;
  logic [31:0] pend_a;

  // reference model state
  logic [1:0]  mbht [64];
  logic [31:0] mras [4];
  logic [1:0]  ras_top;
  logic [2:0]  ras_cnt;
  logic        reg_v, drop;
  logic [31:0] reg_pc, stream_pc;
  int unsigned n_checked;
  frontend_pkg::fetch_entry_t exp_q [$];

  frontend dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      $display("Result: FAILED");
      $fatal(1, "check failed");
    end
  endtask

  // b-type and j-type encoders
  function automatic logic [31:0] enc_b(input logic [31:0] imm);
    enc_b = {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(input logic [31:0] imm, input logic [4:0] rd);
    enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // expected kind and next pc of one word, never a jump to pc+4
  task automatic predict(input logic [31:0] pc, output frontend_pkg::cf_e cf,
                         output logic [31:0] tgt, output logic tk);
    int unsigned i;
    i   = pc[9:2];
    cf  = frontend_pkg::no_cf;
    tgt = pc + 32'd4;
    tk  = 1'b0;
    case (kind_mem[i])
      3'd1: begin
        cf = frontend_pkg::branch;
        if (mbht[pc[7:2]][1]) begin
          tgt = pc + imm_mem[i];
          tk  = 1'b1;
        end
      end
      3'd2, 3'd3: begin
        cf  = frontend_pkg::jump;
        tgt = pc + imm_mem[i];
        tk  = 1'b1;
      end
      3'd4: begin
        cf = frontend_pkg::ret;
        if (ras_cnt != 3'd0) begin
          tgt = mras[ras_top];
          tk  = 1'b1;
        end
      end
      default: ;
    endcase
  endtask

  // ----------------------------------------------------------------------
  // memory, one cycle latency
  // ----------------------------------------------------------------------
  always @(posedge clk_i) begin
    pend_v <= fetch_req_o;
    pend_a <= fetch_addr_o;
  end

  always @(negedge clk_i) begin
    rsp_valid_i = pend_v;
    rsp_addr_i  = pend_a;
    rsp_data_i  = mem[pend_a[9:2]];
  end

  // ----------------------------------------------------------------------
  // reference model, one step per clock
  // ----------------------------------------------------------------------
  always @(posedge clk_i) begin : model
    frontend_pkg::fetch_entry_t head;
    frontend_pkg::cf_e cf;
    logic [31:0] tgt;
    logic tk, flush, ev, kill;
    if (!rst_ni) begin
      for (int i = 0; i < 64; i++) mbht[i] = 2'b01;
      ras_top   = '0;
      ras_cnt   = '0;
      reg_v     = 1'b0;
      drop      = 1'b0;
      stream_pc = boot_addr_i;
      exp_q.delete();
    end else begin
      // decode side, entries in order
      if (fetch_valid_o && fetch_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("Decode received an entry that the model did not expect at %0t", $time);
          $display("Result: FAILED");
          $fatal(1, "unexpected entry");
        end
        head = exp_q.pop_front();
        check_value("pc", fetch_pc_o, head.pc);
        check_value("instr", fetch_instr_o, head.instr);
        check_value("cf", 32'(fetch_cf_o), 32'(head.cf));
        check_value("target", fetch_target_o, head.target);
        n_checked++;
      end
      flush = redirect_i | (resolve_valid_i & resolve_mispredict_i);
      ev    = reg_v & ~flush;
      predict(reg_pc, cf, tgt, tk);
      if (ev) begin
        check_value("fetched pc", reg_pc, stream_pc);
        exp_q.push_back('{instr: mem[reg_pc[9:2]], pc: reg_pc, cf: cf, target: tgt});
        stream_pc = tgt;
        if (kind_mem[reg_pc[9:2]] == 3'd3) begin
          ras_top       = ras_top + 2'd1;
          mras[ras_top] = reg_pc + 32'd4;
          if (ras_cnt != 3'd4) ras_cnt = ras_cnt + 3'd1;
        end else if (kind_mem[reg_pc[9:2]] == 3'd4 && ras_cnt != 3'd0) begin
          ras_top = ras_top - 2'd1;
          ras_cnt = ras_cnt - 3'd1;
        end
      end
      kill = (ev & tk) | flush;
      check_value("kill", 32'(kill_o), 32'(kill));
      // saturating counter update
      if (resolve_valid_i && resolve_is_branch_i) begin
        if (resolve_taken_i && mbht[resolve_pc_i[7:2]] != 2'b11)
          mbht[resolve_pc_i[7:2]] = mbht[resolve_pc_i[7:2]] + 2'b01;
        else if (!resolve_taken_i && mbht[resolve_pc_i[7:2]] != 2'b00)
          mbht[resolve_pc_i[7:2]] = mbht[resolve_pc_i[7:2]] - 2'b01;
      end
      if (flush) begin
        exp_q.delete();
        stream_pc = redirect_i ? redirect_pc_i : resolve_target_i;
      end
      reg_v = rsp_valid_i & ~kill & ~drop;
      if (rsp_valid_i) reg_pc = rsp_addr_i;
      drop = flush;
    end
  end

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------
  initial begin
    int unsigned r;
    logic [31:0] off;
    void'($urandom(32'h0e101921));
    for (int i = 0; i < words; i++) begin
      r   = $urandom % 10;
      off = (($urandom % 15) + 2) * 4;
      if ($urandom % 2) off = -off;
      imm_mem[i] = off;
      if (r < 5) begin
        kind_mem[i] = 3'd0;
        mem[i] = {12'($urandom), 5'd0, 3'b000, 5'd3, 7'b0010011};
      end else if (r < 7) begin
        kind_mem[i] = 3'd1;
        mem[i] = enc_b(off);
      end else if (r == 7) begin
        kind_mem[i] = 3'd2;
        mem[i] = enc_j(off, 5'd0);
      end else if (r == 8) begin
        kind_mem[i] = 3'd3;
        mem[i] = enc_j(off, 5'd1);
      end else begin
        kind_mem[i] = 3'd4;
        mem[i] = 32'h00008067;
      end
    end
    n_checked           = 0;
    boot_addr_i         = 32'h0000_0100;
    rsp_valid_i         = 1'b0;
    rsp_addr_i          = '0;
    rsp_data_i          = '0;
    redirect_i          = 1'b0;
    redirect_pc_i       = '0;
    fetch_ready_i       = 1'b0;
    resolve_valid_i     = 1'b0;
    resolve_pc_i        = '0;
    resolve_taken_i     = 1'b0;
    resolve_mispredict_i = 1'b0;
    resolve_is_branch_i = 1'b0;
    resolve_target_i    = '0;
    rst_ni              = 1'b0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    // nothing valid, killed or requested in the first cycle
    @(posedge clk_i);
    check_value("first cycle valid", 32'(fetch_valid_o), 32'd0);
    check_value("first cycle kill", 32'(kill_o), 32'd0);
    check_value("first cycle request", 32'(fetch_req_o), 32'd0);
    while (n_checked < n_tests) begin
      @(negedge clk_i);
      fetch_ready_i        = ($urandom % 4) != 0;
      resolve_valid_i      = ($urandom % 6) == 0;
      resolve_pc_i         = {22'd0, 8'($urandom), 2'b00};
      resolve_taken_i      = $urandom % 2;
      resolve_is_branch_i  = ($urandom % 4) != 0;
      resolve_mispredict_i = ($urandom % 8) == 0;
      resolve_target_i     = {22'd0, 8'($urandom), 2'b00};
      redirect_i           = ($urandom % 50) == 0;
      redirect_pc_i        = {22'd0, 8'($urandom), 2'b00};
      // decode holds while the queue is flushed
      if (redirect_i || (resolve_valid_i && resolve_mispredict_i)) fetch_ready_i = 1'b0;
    end
    $display("Result: PASSED");
    $finish;
  end

  // watchdog
  initial begin
    repeat (n_tests * 20) @(posedge clk_i);
    $display("Timeout: too few entries reached decode in time");
    $display("Result: FAILED");
    $fatal(1, "timeout");
  end

endmodule

// File: all.f
common/frontend_pkg.sv
common/fetch_if.sv
predict/instr_scan.sv
predict/bht.sv
predict/ras.sv
src/pc_gen.sv
src/fetch_stage.sv
src/fetch_queue.sv
src/frontend.sv
test/frontend_assert.sv
test/tb_frontend.sv

// File: run.sh
#!/bin/sh
# build and run the front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_frontend \
  -f all.f --Mdir obj_dir -o tb_frontend
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/tb_frontend)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  exit 1
fi

if echo "$out" | grep -q "^Result: PASSED$"; then
  exit 0
fi
exit 1
